//--- filelist.f
+incdir+testbench
verilog/ec_pkg.sv
verilog/fe_stream_if.sv
verilog/fe_mod_mult.sv
verilog/fe_mod_reduce.sv
verilog/point_add_ctrl.sv
verilog/point_add_top.sv
testbench/tb_point_add.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the point adder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f \
  --top-module tb_point_add \
  -o sim_point_add

status=0
./obj_dir/sim_point_add > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TEST PASSED" sim.log; then
  echo "Simulation ended without a pass result"
  exit 1
fi
echo "Simulation passed"

//--- testbench/tb_ec_model.svh
/*
  Reference arithmetic mod the secp256k1 prime and Jacobian point addition
  Special cases compare raw words, in the order Z zero, X equal with Y differing, X and Y equal
*/
`ifndef TB_EC_MODEL_SVH
`define TB_EC_MODEL_SVH

// secp256k1 prime p = 2^256 - 2^32 - 977
localparam logic [255:0] MODEL_P =
  256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;

function automatic logic [255:0] add_mod(input logic [255:0] a, input logic [255:0] b);
  logic [256:0] s;
  s = {1'b0, a} + {1'b0, b};
  if (s >= {1'b0, MODEL_P}) s = s - {1'b0, MODEL_P};
  return s[255:0];
endfunction

function automatic logic [255:0] sub_mod(input logic [255:0] a, input logic [255:0] b);
  if (a >= b) return a - b;
  return a + (MODEL_P - b);  // Stays below p, no carry out
endfunction

// Full 512-bit product, then one wide remainder
function automatic logic [255:0] mul_mod(input logic [255:0] a, input logic [255:0] b);
  logic [511:0] t;
  t = {256'd0, a} * {256'd0, b};
  t = t % {256'd0, MODEL_P};
  return t[255:0];
endfunction

function automatic void add_points(
  input  logic [255:0] x1, input logic [255:0] y1, input logic [255:0] z1,
  input  logic [255:0] x2, input logic [255:0] y2, input logic [255:0] z2,
  output logic [255:0] x3, output logic [255:0] y3, output logic [255:0] z3,
  output logic err, output logic early
);
  logic [255:0] z1s, z2s, u1, u2, s1, s2, h, r, h2, h3, u1h2;
  err   = 1'b0;
  early = 1'b1;
  x3    = '0;
  y3    = '0;
  z3    = '0;
  if (z1 == '0) begin
    x3 = x2;  // Infinity plus Q
    y3 = y2;
    z3 = z2;
  end else if (z2 == '0) begin
    x3 = x1;
    y3 = y1;
    z3 = z1;
  end else if (x1 == x2) begin
    err = (y1 == y2);  // Same words need doubling, else infinity
  end else begin
    early = 1'b0;
    z1s   = mul_mod(z1, z1);
    z2s   = mul_mod(z2, z2);
    u1    = mul_mod(x1, z2s);
    u2    = mul_mod(x2, z1s);
    s1    = mul_mod(y1, mul_mod(z2s, z2));
    s2    = mul_mod(y2, mul_mod(z1s, z1));
    h     = sub_mod(u2, u1);
    r     = sub_mod(s2, s1);
    h2    = mul_mod(h, h);
    h3    = mul_mod(h2, h);
    u1h2  = mul_mod(u1, h2);
    x3    = sub_mod(sub_mod(mul_mod(r, r), h3), add_mod(u1h2, u1h2));
    y3    = sub_mod(mul_mod(r, sub_mod(u1h2, x3)), mul_mod(s1, h3));
    z3    = mul_mod(h, mul_mod(z1, z2));
  end
endfunction

`endif

//--- testbench/tb_point_add.sv
/*
  Random point additions against a reference model, seed 6, DIGIT_BITS 2
  Stops at the first error; the DUT holds one transaction at a time
*/
`timescale 1ns/10ps

module tb_point_add;
  import ec_pkg::*;

  localparam int NTRANS    = 40;
  localparam int RAND_SEED = 6;
  localparam int MAX_CYC   = NTRANS * (16 * 130 + 200);  // 16 multiplies of 130 cycles each

  `include "tb_ec_model.svh"

  typedef struct packed {
    fe_t  x;
    fe_t  y;
    fe_t  z;
    logic err;
  } exp_t;

  logic i_clk = 1'b0;
  logic i_rst;
  fe_t  i_p1_x, i_p1_y, i_p1_z;
  fe_t  i_p2_x, i_p2_y, i_p2_z;
  logic i_val;
  logic i_rdy;
  logic o_rdy, o_val, o_err;
  fe_t  o_p_x, o_p_y, o_p_z;

  exp_t exp_q[$];      // Expected results in input order
  int   done_cnt = 0;  // Output transfers seen
  int   cyc      = 0;

  point_add_top #(.DIGIT_BITS(2)) dut0 (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_p1_x (i_p1_x),
    .i_p1_y (i_p1_y),
    .i_p1_z (i_p1_z),
    .i_p2_x (i_p2_x),
    .i_p2_y (i_p2_y),
    .i_p2_z (i_p2_z),
    .i_val  (i_val),
    .o_rdy  (o_rdy),
    .o_p_x  (o_p_x),
    .o_p_y  (o_p_y),
    .o_p_z  (o_p_z),
    .o_val  (o_val),
    .o_err  (o_err),
    .i_rdy  (i_rdy)
  );

  always #5 i_clk = ~i_clk;

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_val(input string name, input fe_t got, input fe_t exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      stop_with_error("Wrong value from the DUT");
    end
  endtask

  // Near-uniform element below p
  function automatic fe_t rand_fe();
    fe_t v;
    for (int i = 0; i < 8; i++) v[32*i +: 32] = $urandom;
    if (v >= MODEL_P) v = v - MODEL_P;
    return v;
  endfunction

  // Kinds 0..4 are special cases, the rest general additions
  task automatic send_one(input int n);
    fe_t  x1, y1, z1, x2, y2, z2;
    exp_t e;
    logic early;
    int   kind;
    kind = (n < 5) ? n : int'($urandom_range(0, 9));  // First five cover every case
    x1   = rand_fe();
    y1   = rand_fe();
    z1   = rand_fe();
    x2   = rand_fe();
    y2   = rand_fe();
    z2   = rand_fe();
    case (kind)
      0: z1 = '0;
      1: z2 = '0;
      2: begin
        x2 = x1;  // Opposite points
        if (y2 == y1) y2 = add_mod(y1, 256'd1);
      end
      3: begin
        x2 = x1;  // Same words, doubling request
        y2 = y1;
      end
      4: begin
        z1 = '0;
        z2 = '0;
      end
      default: if (x2 == x1) x2 = add_mod(x1, 256'd1);
    endcase
    add_points(x1, y1, z1, x2, y2, z2, e.x, e.y, e.z, e.err, early);

    @(negedge i_clk);
    i_p1_x = x1;
    i_p1_y = y1;
    i_p1_z = z1;
    i_p2_x = x2;
    i_p2_y = y2;
    i_p2_z = z2;
    i_val  = 1'b1;
    while (!o_rdy) @(negedge i_clk);  // Hold until the DUT is ready
    exp_q.push_back(e);                // Taken on the next rising edge
    @(negedge i_clk);
    i_val = 1'b0;
    if (early) check_val("o_val", o_val, 1'b1);  // Early exit shows after one cycle
  endtask

  // Output side: random back-pressure, compare, count transfers
  initial begin : out_monitor
    exp_t cur;
    logic holding;
    logic taken;
    holding = 1'b0;
    taken   = 1'b0;
    i_rdy   = 1'b0;
    forever begin
      @(negedge i_clk);
      if (!i_rst) begin
        if (taken) begin
          check_val("o_val", o_val, 1'b0);  // Not repeated
          check_val("o_rdy", o_rdy, 1'b1);
          taken = 1'b0;
        end else if (o_val) begin
          if (!holding) begin
            if (exp_q.size() == 0) begin
              stop_with_error("Output valid with no transaction pending");
            end else begin
              cur     = exp_q[0];
              holding = 1'b1;
              if (cur.err) begin
                cur.x = o_p_x;  // Value unspecified on error, only held stable
                cur.y = o_p_y;
                cur.z = o_p_z;
              end
            end
          end
          check_val("o_err", o_err, cur.err);
          check_val("o_p_x", o_p_x, cur.x);
          check_val("o_p_y", o_p_y, cur.y);
          check_val("o_p_z", o_p_z, cur.z);
        end else if (holding) begin
          check_val("o_val", o_val, 1'b1);  // Dropped before the transfer
        end
        i_rdy = ($urandom_range(0, 2) == 0);
        if (o_val && holding && i_rdy) begin
          void'(exp_q.pop_front());  // Transfer at the next rising edge
          holding = 1'b0;
          taken   = 1'b1;
          done_cnt++;
        end
      end
    end
  end

  always @(posedge i_clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYC) begin
      stop_with_error($sformatf("Timeout, run did not finish in %0d cycles", MAX_CYC));
    end
  end

  initial begin : main
    void'($urandom(RAND_SEED));
    i_rst  = 1'b1;
    i_val  = 1'b0;
    i_p1_x = '0;
    i_p1_y = '0;
    i_p1_z = '0;
    i_p2_x = '0;
    i_p2_y = '0;
    i_p2_z = '0;
    repeat (3) @(negedge i_clk);
    i_rst = 1'b0;
    check_val("o_val", o_val, 1'b0);
    check_val("o_err", o_err, 1'b0);
    @(negedge i_clk);
    check_val("o_rdy", o_rdy, 1'b1);  // Ready one cycle after reset

    for (int n = 0; n < NTRANS; n++) begin
      repeat ($urandom_range(0, 3)) @(negedge i_clk);
      send_one(n);
    end
    while (done_cnt < NTRANS) @(negedge i_clk);
    repeat (2) @(negedge i_clk);  // Let the post-transfer checks run

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- verilog/ec_pkg.sv
/*
  secp256k1 field and point types shared by the point adder
  Field elements are raw 256-bit words and callers keep them below p
*/
package ec_pkg;

  // Field element width
  localparam int FE_W = 256;

  // Steps in the Jacobian addition schedule
  localparam int NSTEP = 24;

  // secp256k1 prime p = 2^256 - 2^32 - 977
  localparam logic [FE_W-1:0] P_MOD =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;

  typedef logic [FE_W-1:0] fe_t;

  // Jacobian point, z == 0 is the point at infinity
  typedef struct packed {
    fe_t x;
    fe_t y;
    fe_t z;
  } jb_point_t;

  // Step number 0..23, travels as the request tag
  typedef logic [4:0] step_t;

  // Operand pair for the multiplier
  typedef struct packed {
    fe_t b;  // Scanned digit by digit
    fe_t a;  // Digit multiples of a are added
  } fe_pair_t;

  // One request word, two views
  typedef union packed {
    fe_pair_t              op;    // Multiplier operands
    logic [2*FE_W-1:0]     wide;  // Reducer input, low 258 bits used
  } fe_req_u;

endpackage

//--- verilog/fe_mod_mult.sv
/*
  Digit-serial a*b mod p, one request at a time, latency 256/DIGIT_BITS + 2
  DIGIT_BITS must be 1, 2 or 4; b may be any 256-bit word, a is reduced once
*/
`timescale 1ns/10ps

module fe_mod_mult #(
  parameter int DIGIT_BITS = 2
) (
  input  logic        i_clk,
  input  logic        i_rst,
  fe_stream_if.sink   i_req,
  fe_stream_if.source o_rsp
);
  import ec_pkg::*;

  localparam int NDIG = FE_W / DIGIT_BITS;        // Digits in b
  localparam int CW   = $clog2(NDIG);
  localparam int XW   = FE_W + DIGIT_BITS + 1;    // Room for acc + digit*a

  typedef enum logic [1:0] {S_IDLE, S_PREP, S_LOOP, S_OUT} state_e;

  state_e                state;
  fe_req_u               req;
  fe_t                   a_q, b_q, acc;
  step_t                 tag_q;
  logic [CW-1:0]         cnt;
  logic [DIGIT_BITS-1:0] dig;
  logic [XW-1:0]         sum;
  fe_t                   acc_nxt;

  assign req = i_req.dat;
  assign dig = b_q[FE_W-1 -: DIGIT_BITS];  // MSB digit first

  // One Horner step: acc*2^D + dig*a, kept below p
  always_comb begin
    sum = XW'(acc);
    for (int i = 0; i < DIGIT_BITS; i++) begin
      sum = sum << 1;                                  // < 2p
      if (sum >= XW'(P_MOD)) sum = sum - XW'(P_MOD);
    end
    sum = sum + XW'(a_q) * XW'(dig);                   // < 2^D * p
    // Binary descent over p*2^k leaves sum < p
    for (int k = DIGIT_BITS - 1; k >= 0; k--) begin
      if (sum >= (XW'(P_MOD) << k)) sum = sum - (XW'(P_MOD) << k);
    end
    acc_nxt = sum[FE_W-1:0];
  end

  assign i_req.rdy = (state == S_IDLE);  // Busy unit refuses requests
  assign o_rsp.dat = acc;
  assign o_rsp.tag = tag_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= S_IDLE;
      o_rsp.val <= 1'b0;
    end else begin
      case (state)
        S_IDLE: if (i_req.val) begin
          a_q   <= req.op.a;
          b_q   <= req.op.b;
          tag_q <= i_req.tag;
          acc   <= '0;
          state <= S_PREP;
        end
        S_PREP: begin
          a_q   <= (a_q >= P_MOD) ? a_q - P_MOD : a_q;  // a below p
          cnt   <= '0;
          state <= S_LOOP;
        end
        S_LOOP: begin
          acc <= acc_nxt;
          b_q <= b_q << DIGIT_BITS;
          cnt <= cnt + 1'b1;
          if (cnt == CW'(NDIG - 1)) state <= S_OUT;     // Last digit
        end
        S_OUT: begin
          if (!o_rsp.val) begin
            o_rsp.val <= 1'b1;
          end else if (o_rsp.rdy) begin
            o_rsp.val <= 1'b0;
            state     <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Every loop step leaves a canonical accumulator
  a_acc_lt_p : assert property (@(posedge i_clk) disable iff (i_rst)
    (state != S_IDLE) |-> (acc < P_MOD));

endmodule

//--- verilog/fe_mod_reduce.sv
/*
  Reduces the low 258 bits of a request mod p, input must be below 4p
  Latency 1 to 4 cycles, one subtraction per cycle
*/
`timescale 1ns/10ps

module fe_mod_reduce (
  input  logic        i_clk,
  input  logic        i_rst,
  fe_stream_if.sink   i_req,
  fe_stream_if.source o_rsp
);
  import ec_pkg::*;

  localparam logic [FE_W+1:0] P_EXT = {2'b00, P_MOD};
  localparam logic [FE_W+1:0] P_X4  = {P_MOD, 2'b00};  // 4p, input bound

  typedef enum logic [1:0] {S_IDLE, S_SUB, S_OUT} state_e;

  state_e          state;
  fe_req_u         req;
  logic [FE_W+1:0] v;      // Working value
  step_t           tag_q;
  logic [1:0]      cnt;    // Subtractions done

  assign req       = i_req.dat;
  assign i_req.rdy = (state == S_IDLE);
  assign o_rsp.dat = v[FE_W-1:0];
  assign o_rsp.tag = tag_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= S_IDLE;
      o_rsp.val <= 1'b0;
    end else begin
      case (state)
        S_IDLE: if (i_req.val) begin
          v     <= req.wide[FE_W+1:0];
          tag_q <= i_req.tag;
          cnt   <= '0;
          state <= S_SUB;
        end
        S_SUB: begin
          if (v >= P_EXT && cnt != 2'd3) begin
            v   <= v - P_EXT;
            cnt <= cnt + 1'b1;
          end else begin
            o_rsp.val <= 1'b1;  // Below p now
            state     <= S_OUT;
          end
        end
        S_OUT: if (o_rsp.rdy) begin
          o_rsp.val <= 1'b0;
          state     <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Three subtractions only cover inputs below 4p
  a_in_lt_4p : assert property (@(posedge i_clk) disable iff (i_rst)
    (i_req.val && i_req.rdy) |-> (req.wide[FE_W+1:0] < P_X4));

endmodule

//--- verilog/fe_stream_if.sv
/*
  Valid/ready stream carrying one word and its step tag
  Source holds dat and tag while val is high and rdy is low
*/
`timescale 1ns/10ps

interface fe_stream_if #(
  parameter int DAT_W = 256
) ();
  import ec_pkg::*;

  logic [DAT_W-1:0] dat;  // Operand or result word
  step_t            tag;  // Step number, echoed back with the result
  logic             val;
  logic             rdy;

  // Producer side
  modport source (
    output dat,
    output tag,
    output val,
    input  rdy
  );

  // Consumer side
  modport sink (
    input  dat,
    input  tag,
    input  val,
    output rdy
  );

endinterface

//--- verilog/point_add_ctrl.sv
/*
  Jacobian point addition on secp256k1, one transaction in flight
  Special cases compare raw words; P1 == P2 is reported on o_err, no doubling
*/
`timescale 1ns/10ps

module point_add_ctrl (
  input  logic              i_clk,
  input  logic              i_rst,
  input  ec_pkg::jb_point_t i_p1,
  input  ec_pkg::jb_point_t i_p2,
  input  logic              i_val,
  output logic              o_rdy,
  output ec_pkg::jb_point_t o_p,
  output logic              o_val,
  output logic              o_err,
  input  logic              i_rdy,
  fe_stream_if.source       o_mul,   // Requests to the multiplier
  fe_stream_if.sink         i_mul,   // Multiplier results
  fe_stream_if.source       o_red,   // Requests to the reducer
  fe_stream_if.sink         i_red    // Reducer results
);
  import ec_pkg::*;

  /*
    U1 = X1*Z2^2, U2 = X2*Z1^2, S1 = Y1*Z2^3, S2 = Y2*Z1^3, H = U2-U1, R = S2-S1
    X3 = R^2 - H^3 - 2*U1*H^2, Y3 = R*(U1*H^2 - X3) - S1*H^3, Z3 = H*Z1*Z2
    Latched inputs are reused as scratch once their first value is consumed
  */
  localparam step_t ST_CPY = 5'd15;  // Y3 <= U1*H^2
  localparam step_t ST_DBL = 5'd16;  // Doubling on the reducer

  localparam logic [NSTEP-1:0] MUL_MASK = 24'hD85CFF;
  localparam logic [NSTEP-1:0] SUB_MASK = 24'h262300;

  // Steps that must be valid before each step may start
  localparam logic [NSTEP-1:0] DEPS [NSTEP] = '{
    24'h000000,  // 0  A = Z2^2
    24'h000001,  // 1  X1 = A*X1 (U1)
    24'h000000,  // 2  C = Z1^2
    24'h000004,  // 3  X2 = C*X2 (U2)
    24'h000002,  // 4  A = A*Z2, after U1 read A
    24'h000010,  // 5  A = A*Y1 (S1)
    24'h000008,  // 6  C = C*Z1, after U2 read C
    24'h000040,  // 7  C = C*Y2 (S2)
    24'h00000A,  // 8  B = U2 - U1 (H)
    24'h0000A0,  // 9  Y2 = S2 - S1 (R)
    24'h000200,  // 10 X3 = R^2
    24'h000100,  // 11 D = H^2
    24'h000900,  // 12 X2 = D*H (H^3)
    24'h001400,  // 13 X3 = X3 - H^3
    24'h000802,  // 14 X1 = U1*D
    24'h004000,  // 15 Y3 = U1*H^2
    24'h00C000,  // 16 X1 = 2*X1
    24'h012000,  // 17 X3 = X3 - X1
    24'h028000,  // 18 Y3 = Y3 - X3
    24'h040200,  // 19 Y3 = Y3*R
    24'h003020,  // 20 X2 = H^3*S1, once step 13 has read H^3
    24'h180000,  // 21 Y3 = Y3 - X2
    24'h000000,  // 22 Z3 = Z1*Z2
    24'h400100   // 23 Z3 = Z3*H
  };

  typedef enum logic [1:0] {IDLE, RUN, DONE} state_e;

  state_e           state;
  jb_point_t        p1_q, p2_q;          // Latched inputs, later scratch
  fe_t              t_a, t_b, t_c, t_d;  // Temporaries
  logic [NSTEP-1:0] step_val;            // Result written
  logic [NSTEP-1:0] step_iss;            // Sent or done
  logic [NSTEP-1:0] step_rdy;            // Inputs valid, not yet issued
  logic             mul_any;
  step_t            mul_sel;
  fe_t              op_a, op_b;
  fe_req_u          mul_word, red_word;

  // Modular subtraction with both inputs below p
  function automatic fe_t fe_sub(input fe_t a, input fe_t b);
    return a - b + ((b > a) ? P_MOD : '0);
  endfunction

  always_comb begin
    mul_any = 1'b0;
    mul_sel = '0;
    for (int s = 0; s < NSTEP; s++) begin
      step_rdy[s] = ((step_val & DEPS[s]) == DEPS[s]) && !step_iss[s];
    end
    for (int s = NSTEP - 1; s >= 0; s--) begin  // Lowest step number wins
      if (MUL_MASK[s] && step_rdy[s]) begin
        mul_any = 1'b1;
        mul_sel = step_t'(s);
      end
    end
  end

  // Operand mux for the selected multiplication
  always_comb begin
    case (mul_sel)
      5'd0:    {op_a, op_b} = {p2_q.z, p2_q.z};
      5'd1:    {op_a, op_b} = {t_a, p1_q.x};
      5'd2:    {op_a, op_b} = {p1_q.z, p1_q.z};
      5'd3:    {op_a, op_b} = {t_c, p2_q.x};
      5'd4:    {op_a, op_b} = {t_a, p2_q.z};
      5'd5:    {op_a, op_b} = {t_a, p1_q.y};
      5'd6:    {op_a, op_b} = {t_c, p1_q.z};
      5'd7:    {op_a, op_b} = {t_c, p2_q.y};
      5'd10:   {op_a, op_b} = {p2_q.y, p2_q.y};  // R^2
      5'd11:   {op_a, op_b} = {t_b, t_b};
      5'd12:   {op_a, op_b} = {t_d, t_b};
      5'd14:   {op_a, op_b} = {t_d, p1_q.x};
      5'd19:   {op_a, op_b} = {o_p.y, p2_q.y};
      5'd20:   {op_a, op_b} = {p2_q.x, t_a};
      5'd22:   {op_a, op_b} = {p1_q.z, p2_q.z};
      5'd23:   {op_a, op_b} = {o_p.z, t_b};
      default: {op_a, op_b} = {p2_q.z, p2_q.z};
    endcase
    mul_word.op.a = op_a;
    mul_word.op.b = op_b;
    red_word.wide = {{(FE_W - 1){1'b0}}, p1_q.x, 1'b0};  // 2*U1*H^2 < 2p
  end

  assign i_mul.rdy = (state == RUN);  // Results only land while running
  assign i_red.rdy = (state == RUN);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= IDLE;
      o_rdy     <= 1'b0;
      o_val     <= 1'b0;
      o_err     <= 1'b0;
      o_mul.val <= 1'b0;
      o_red.val <= 1'b0;
      step_val  <= '0;
      step_iss  <= '0;
    end else begin
      if (o_mul.rdy) o_mul.val <= 1'b0;  // Request taken
      if (o_red.rdy) o_red.val <= 1'b0;
      case (state)
        IDLE: begin
          o_rdy <= 1'b1;
          if (i_val && o_rdy) begin
            o_rdy    <= 1'b0;
            p1_q     <= i_p1;
            p2_q     <= i_p2;
            step_val <= '0;
            step_iss <= '0;
            state    <= RUN;
            if (i_p1.z == '0 || i_p2.z == '0) begin
              o_p   <= (i_p1.z == '0) ? i_p2 : i_p1;  // Infinity plus Q
              o_val <= 1'b1;
              state <= DONE;
            end else if (i_p1.x == i_p2.x) begin
              o_p   <= '0;                       // Opposite points give infinity
              o_err <= (i_p1.y == i_p2.y);       // Same point needs doubling
              o_val <= 1'b1;
              state <= DONE;
            end
          end
        end
        RUN: begin
          // Multiplier results go where the tag says
          if (i_mul.val && i_mul.rdy) begin
            step_val[i_mul.tag] <= 1'b1;
            case (i_mul.tag)
              5'd0, 5'd4, 5'd5:   t_a    <= i_mul.dat;
              5'd1, 5'd14:        p1_q.x <= i_mul.dat;
              5'd2, 5'd6, 5'd7:   t_c    <= i_mul.dat;
              5'd3, 5'd12, 5'd20: p2_q.x <= i_mul.dat;
              5'd10:              o_p.x  <= i_mul.dat;
              5'd11:              t_d    <= i_mul.dat;
              5'd19:              o_p.y  <= i_mul.dat;
              5'd22, 5'd23:       o_p.z  <= i_mul.dat;
              default: ;
            endcase
          end
          if (i_red.val && i_red.rdy) begin
            step_val[i_red.tag] <= 1'b1;
            p1_q.x              <= i_red.dat;  // Only the doubling step
          end

          if (mul_any && (!o_mul.val || o_mul.rdy)) begin
            o_mul.val         <= 1'b1;
            o_mul.dat         <= mul_word;
            o_mul.tag         <= mul_sel;
            step_iss[mul_sel] <= 1'b1;
          end
          if (step_rdy[ST_DBL] && (!o_red.val || o_red.rdy)) begin
            o_red.val        <= 1'b1;
            o_red.dat        <= red_word;
            o_red.tag        <= ST_DBL;
            step_iss[ST_DBL] <= 1'b1;
          end

          // Local subtractions finish in one cycle
          for (int s = 0; s < NSTEP; s++) begin
            if (SUB_MASK[s] && step_rdy[s]) begin
              step_iss[s] <= 1'b1;
              step_val[s] <= 1'b1;
              case (s)
                8:       t_b    <= fe_sub(p2_q.x, p1_q.x);
                9:       p2_q.y <= fe_sub(t_c, t_a);
                13:      o_p.x  <= fe_sub(o_p.x, p2_q.x);
                17:      o_p.x  <= fe_sub(o_p.x, p1_q.x);
                18:      o_p.y  <= fe_sub(o_p.y, o_p.x);
                default: o_p.y  <= fe_sub(o_p.y, p2_q.x);  // Step 21
              endcase
            end
          end
          if (step_rdy[ST_CPY]) begin
            step_iss[ST_CPY] <= 1'b1;
            step_val[ST_CPY] <= 1'b1;
            o_p.y            <= p1_q.x;
          end

          if (&step_val) begin
            o_val <= 1'b1;
            state <= DONE;
          end
        end
        DONE: if (i_rdy) begin  // Result held until taken
          o_val <= 1'b0;
          o_err <= 1'b0;
          o_rdy <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // A result must belong to an outstanding step
  a_mul_tag : assert property (@(posedge i_clk) disable iff (i_rst)
    (i_mul.val && i_mul.rdy) |-> (step_iss[i_mul.tag] && !step_val[i_mul.tag]));
  a_red_tag : assert property (@(posedge i_clk) disable iff (i_rst)
    (i_red.val && i_red.rdy) |-> (step_iss[i_red.tag] && !step_val[i_red.tag]));

  // Output valid only once a result is complete
  a_val_idle : assert property (@(posedge i_clk) disable iff (i_rst)
    o_val |-> (state == DONE));

endmodule

//--- verilog/point_add_top.sv
/*
  secp256k1 Jacobian point adder with plain valid/ready ports
  DIGIT_BITS sets the multiplier digit size and must be 1, 2 or 4
*/
`timescale 1ns/10ps

module point_add_top #(
  parameter int DIGIT_BITS = 2
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  ec_pkg::fe_t i_p1_x,
  input  ec_pkg::fe_t i_p1_y,
  input  ec_pkg::fe_t i_p1_z,
  input  ec_pkg::fe_t i_p2_x,
  input  ec_pkg::fe_t i_p2_y,
  input  ec_pkg::fe_t i_p2_z,
  input  logic        i_val,
  output logic        o_rdy,
  output ec_pkg::fe_t o_p_x,
  output ec_pkg::fe_t o_p_y,
  output ec_pkg::fe_t o_p_z,
  output logic        o_val,
  output logic        o_err,
  input  logic        i_rdy
);
  import ec_pkg::*;

  jb_point_t p1, p2, p_out;

  assign p1    = '{x: i_p1_x, y: i_p1_y, z: i_p1_z};
  assign p2    = '{x: i_p2_x, y: i_p2_y, z: i_p2_z};
  assign o_p_x = p_out.x;
  assign o_p_y = p_out.y;
  assign o_p_z = p_out.z;

  // Request streams carry the operand union, responses one element
  fe_stream_if #(.DAT_W(2 * FE_W)) mul_req ();
  fe_stream_if #(.DAT_W(FE_W))     mul_rsp ();
  fe_stream_if #(.DAT_W(2 * FE_W)) red_req ();
  fe_stream_if #(.DAT_W(FE_W))     red_rsp ();

  point_add_ctrl ctrl0 (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_p1  (p1),
    .i_p2  (p2),
    .i_val (i_val),
    .o_rdy (o_rdy),
    .o_p   (p_out),
    .o_val (o_val),
    .o_err (o_err),
    .i_rdy (i_rdy),
    .o_mul (mul_req),
    .i_mul (mul_rsp),
    .o_red (red_req),
    .i_red (red_rsp)
  );

  fe_mod_mult #(.DIGIT_BITS(DIGIT_BITS)) mult0 (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_req (mul_req),
    .o_rsp (mul_rsp)
  );

  fe_mod_reduce red0 (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_req (red_req),
    .o_rsp (red_rsp)
  );

endmodule
